//--- rtl/mnt_pkg.sv
package mnt_pkg;

  // frame coordinates and counts
  typedef logic [10:0] coord_x_t;
  typedef logic [9:0]  coord_y_t;
  typedef logic [16:0] perim_t;

  // one step along an axis in two's complement
  typedef logic [1:0] delta_t;

  localparam delta_t D_NEG  = 2'b11;
  localparam delta_t D_ZERO = 2'b00;
  localparam delta_t D_POS  = 2'b01;

  typedef struct packed {
    coord_x_t x;
    coord_y_t y;
    logic     masked;  // pixel is part of the mask
    logic     sof;     // first pixel of a frame
  } pixel_t;

  // neighbors in clockwise order from up-left
  typedef logic [7:0] nbr_t;

  localparam int NB_UL = 0;
  localparam int NB_U  = 1;
  localparam int NB_UR = 2;
  localparam int NB_R  = 3;
  localparam int NB_DR = 4;
  localparam int NB_D  = 5;
  localparam int NB_DL = 6;
  localparam int NB_L  = 7;

  // side the tracer entered the current pixel from
  typedef enum logic [1:0] {DIR_UP, DIR_RIGHT, DIR_DOWN, DIR_LEFT} dir_t;

  typedef struct packed {
    logic     found;
    coord_x_t start_x;
    coord_y_t start_y;
    perim_t   perimeter;
  } result_t;

  localparam int DEF_WIDTH  = 320;
  localparam int DEF_HEIGHT = 180;

endpackage

//--- rtl/mask_bram.sv
`timescale 1ns/1ps

module mask_bram #(
  parameter int DEPTH = 1024
) (
  input  logic                     clk_in,
  input  logic                     a_we,
  input  logic [$clog2(DEPTH)-1:0] a_addr,
  input  logic                     a_wdata,
  output logic                     a_rdata,
  input  logic [$clog2(DEPTH)-1:0] b_addr,
  output logic                     b_rdata
);

  logic mem [DEPTH];  // one bit per pixel

  // read-first on both ports so a write returns the old data
  always_ff @(posedge clk_in) begin
    if (a_we) begin
      mem[a_addr] <= a_wdata;
    end
    a_rdata <= mem[a_addr];
    b_rdata <= mem[b_addr];
  end

endmodule

//--- rtl/neighbor_window.sv
`timescale 1ns/1ps

module neighbor_window #(
  parameter int WIDTH  = mnt_pkg::DEF_WIDTH,
  parameter int HEIGHT = mnt_pkg::DEF_HEIGHT
) (
  input  logic              clk_in,
  input  logic              wr_en,
  input  mnt_pkg::pixel_t   wr_pix,
  input  mnt_pkg::coord_x_t fetch_x,
  input  mnt_pkg::coord_y_t fetch_y,
  input  logic              fetch_center,
  output mnt_pkg::nbr_t     nbr,
  output logic              center_bit
);
  import mnt_pkg::*;

  localparam int DEPTH  = WIDTH * HEIGHT;
  localparam int ADDR_W = $clog2(DEPTH);

  logic [ADDR_W-1:0] wr_addr;
  logic [ADDR_W-1:0] a_addr [4];
  logic [ADDR_W-1:0] b_addr [4];
  logic [3:0]        a_rdata;
  logic [3:0]        b_rdata;

  coord_x_t ctr_x_q;
  coord_y_t ctr_y_q;
  logic     center_q;
  logic     left_ok;
  logic     right_ok;
  logic     up_ok;
  logic     down_ok;

  // out-of-frame neighbors read address 0 and are masked below
  function automatic logic [ADDR_W-1:0] nbr_addr(input coord_x_t cx, input coord_y_t cy,
                                                 input int dx, input int dy);
    int nx;
    int ny;
    nx = int'(cx) + dx;
    ny = int'(cy) + dy;
    if (nx < 0 || nx >= WIDTH || ny < 0 || ny >= HEIGHT) begin
      return '0;
    end
    return ADDR_W'(nx + ny * WIDTH);
  endfunction

  assign wr_addr = ADDR_W'(int'(wr_pix.x) + int'(wr_pix.y) * WIDTH);

  always_comb begin
    // bank 0 port B doubles as the center read during search
    b_addr[0] = fetch_center ? nbr_addr(fetch_x, fetch_y, 0, 0)
                             : nbr_addr(fetch_x, fetch_y, 0, -1);
    b_addr[1] = nbr_addr(fetch_x, fetch_y, 1, 0);   // right
    b_addr[2] = nbr_addr(fetch_x, fetch_y, 0, 1);   // down
    b_addr[3] = nbr_addr(fetch_x, fetch_y, -1, 0);  // left
    if (wr_en) begin
      for (int b = 0; b < 4; b++) begin
        a_addr[b] = wr_addr;  // every bank keeps a full copy
      end
    end else begin
      a_addr[0] = nbr_addr(fetch_x, fetch_y, -1, -1);  // up-left
      a_addr[1] = nbr_addr(fetch_x, fetch_y, 1, -1);   // up-right
      a_addr[2] = nbr_addr(fetch_x, fetch_y, 1, 1);    // down-right
      a_addr[3] = nbr_addr(fetch_x, fetch_y, -1, 1);   // down-left
    end
  end

  for (genvar g = 0; g < 4; g++) begin : g_bank
    mask_bram #(
      .DEPTH(DEPTH)
    ) u_bank (
      .clk_in  (clk_in),
      .a_we    (wr_en),
      .a_addr  (a_addr[g]),
      .a_wdata (wr_pix.masked),
      .a_rdata (a_rdata[g]),
      .b_addr  (b_addr[g]),
      .b_rdata (b_rdata[g])
    );
  end

  // center lines up with the RAM output
  always_ff @(posedge clk_in) begin
    ctr_x_q  <= fetch_x;
    ctr_y_q  <= fetch_y;
    center_q <= fetch_center;
  end

  assign left_ok  = ctr_x_q != '0;
  assign right_ok = ctr_x_q != coord_x_t'(WIDTH - 1);
  assign up_ok    = ctr_y_q != '0;
  assign down_ok  = ctr_y_q != coord_y_t'(HEIGHT - 1);

  always_comb begin
    nbr[NB_UL] = a_rdata[0] & up_ok & left_ok;
    nbr[NB_U]  = b_rdata[0] & up_ok & ~center_q;
    nbr[NB_UR] = a_rdata[1] & up_ok & right_ok;
    nbr[NB_R]  = b_rdata[1] & right_ok;
    nbr[NB_DR] = a_rdata[2] & down_ok & right_ok;
    nbr[NB_D]  = b_rdata[2] & down_ok;
    nbr[NB_DL] = a_rdata[3] & down_ok & left_ok;
    nbr[NB_L]  = b_rdata[3] & left_ok;
  end

  assign center_bit = b_rdata[0] & center_q;

endmodule

//--- rtl/moore_step.sv
`timescale 1ns/1ps

module moore_step (
  input  mnt_pkg::dir_t   from,
  input  mnt_pkg::nbr_t   nbr,
  output mnt_pkg::delta_t move_dx,
  output mnt_pkg::delta_t move_dy,
  output mnt_pkg::dir_t   next_from,
  output logic            has_move
);
  import mnt_pkg::*;

  logic [2:0] start_idx;
  logic [2:0] cand;
  logic [2:0] hit_idx;

  // up, right, down, left sit on the odd neighbor positions
  assign start_idx = {2'(from), 1'b1};

  // walk backwards so the first set neighbor in clockwise order wins
  always_comb begin
    has_move = 1'b0;
    hit_idx  = '0;
    for (int i = 7; i >= 0; i--) begin
      cand = start_idx + 3'(i);
      if (nbr[cand]) begin
        has_move = 1'b1;
        hit_idx  = cand;
      end
    end
  end

  always_comb begin
    move_dx   = D_ZERO;
    move_dy   = D_ZERO;
    next_from = from;  // isolated pixel stays put
    if (has_move) begin
      case (hit_idx)
        3'(NB_UL): begin
          move_dx   = D_NEG;
          move_dy   = D_NEG;
          next_from = DIR_DOWN;
        end
        3'(NB_U): begin
          move_dy   = D_NEG;
          next_from = DIR_LEFT;
        end
        3'(NB_UR): begin
          move_dx   = D_POS;
          move_dy   = D_NEG;
          next_from = DIR_LEFT;
        end
        3'(NB_R): begin
          move_dx   = D_POS;
          next_from = DIR_UP;
        end
        3'(NB_DR): begin
          move_dx   = D_POS;
          move_dy   = D_POS;
          next_from = DIR_UP;
        end
        3'(NB_D): begin
          move_dy   = D_POS;
          next_from = DIR_RIGHT;
        end
        3'(NB_DL): begin
          move_dx   = D_NEG;
          move_dy   = D_POS;
          next_from = DIR_RIGHT;
        end
        default: begin  // left
          move_dx   = D_NEG;
          next_from = DIR_DOWN;
        end
      endcase
    end
  end

endmodule

//--- rtl/contour_controller.sv
`timescale 1ns/1ps

module contour_controller #(
  parameter int WIDTH  = mnt_pkg::DEF_WIDTH,
  parameter int HEIGHT = mnt_pkg::DEF_HEIGHT
) (
  input  logic              clk_in,
  input  logic              rst_in,
  input  mnt_pkg::pixel_t   pix,
  input  logic              pix_valid,
  output logic              pix_ready,
  output logic              wr_en,
  output mnt_pkg::pixel_t   wr_pix,
  output mnt_pkg::coord_x_t fetch_x,
  output mnt_pkg::coord_y_t fetch_y,
  output logic              fetch_center,
  input  logic              center_bit,
  input  mnt_pkg::delta_t   move_dx,
  input  mnt_pkg::delta_t   move_dy,
  input  mnt_pkg::dir_t     next_from,
  input  logic              has_move,
  output mnt_pkg::dir_t     from,
  output mnt_pkg::result_t  result,
  output logic              result_valid,
  input  logic              result_ready
);
  import mnt_pkg::*;

  localparam coord_x_t X_LAST = coord_x_t'(WIDTH - 1);
  localparam coord_y_t Y_LAST = coord_y_t'(HEIGHT - 1);

  typedef enum logic [2:0] {IDLE, STORE, SEARCH, TRACE, REPORT} state_t;

  state_t   state;
  logic     decide;   // 0 issues the read, 1 uses the data
  coord_x_t pos_x;
  coord_y_t pos_y;
  coord_x_t start_x;
  coord_y_t start_y;
  logic     started;  // at least one trace step taken
  perim_t   perimeter;

  logic     pix_xfer;
  logic     last_pix;
  logic     at_start;
  coord_x_t step_x;
  coord_y_t step_y;

  assign pix_xfer = pix_valid & pix_ready;
  assign last_pix = (pix.x == X_LAST) && (pix.y == Y_LAST);
  assign at_start = (pos_x == start_x) && (pos_y == start_y);

  // sign-extend the moves
  assign step_x = {{($bits(coord_x_t) - 2){move_dx[1]}}, move_dx};
  assign step_y = {{($bits(coord_y_t) - 2){move_dy[1]}}, move_dy};

  assign wr_en  = pix_xfer && (state == STORE || (state == IDLE && pix.sof));
  assign wr_pix = pix;

  assign fetch_x      = pos_x;
  assign fetch_y      = pos_y;
  assign fetch_center = state == SEARCH;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state        <= IDLE;
      decide       <= 1'b0;
      pix_ready    <= 1'b0;
      result_valid <= 1'b0;
      result       <= '0;
      from         <= DIR_UP;
      started      <= 1'b0;
      perimeter    <= '0;
      pos_x        <= '0;
      pos_y        <= '0;
    end else begin
      case (state)
        IDLE: begin
          pix_ready <= 1'b1;
          if (pix_xfer && pix.sof) begin
            state <= STORE;  // sof pixel already written
          end
        end
        STORE: begin
          if (pix_xfer && last_pix) begin
            state     <= SEARCH;
            pix_ready <= 1'b0;
            pos_x     <= '0;
            pos_y     <= '0;
            decide    <= 1'b0;
          end
        end
        SEARCH: begin
          decide <= ~decide;
          if (decide) begin
            if (center_bit) begin
              state     <= TRACE;
              start_x   <= pos_x;
              start_y   <= pos_y;
              perimeter <= perim_t'(1);
              from      <= DIR_UP;
              started   <= 1'b0;
            end else if (pos_x == X_LAST && pos_y == Y_LAST) begin
              state        <= REPORT;  // empty frame
              result       <= '0;
              result_valid <= 1'b1;
            end else if (pos_x == X_LAST) begin
              pos_x <= '0;
              pos_y <= pos_y + 1'b1;
            end else begin
              pos_x <= pos_x + 1'b1;
            end
          end
        end
        TRACE: begin
          decide <= ~decide;
          if (decide) begin
            if (started && at_start) begin
              state        <= REPORT;
              result_valid <= 1'b1;
              result       <= '{found: 1'b1, start_x: start_x, start_y: start_y,
                                perimeter: perimeter};
            end else begin
              started <= 1'b1;
              if (!at_start) begin
                perimeter <= perimeter + 1'b1;
              end
              if (has_move) begin
                pos_x <= pos_x + step_x;
                pos_y <= pos_y + step_y;
                from  <= next_from;
              end
            end
          end
        end
        REPORT: begin
          // result holds until the sink takes it
          if (result_ready) begin
            result_valid <= 1'b0;
            pix_ready    <= 1'b1;
            state        <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

//--- rtl/contour_tracer_top.sv
`timescale 1ns/1ps

module contour_tracer_top #(
  parameter int WIDTH  = mnt_pkg::DEF_WIDTH,
  parameter int HEIGHT = mnt_pkg::DEF_HEIGHT
) (
  input  logic             clk_in,
  input  logic             rst_in,
  input  mnt_pkg::pixel_t  pix,
  input  logic             pix_valid,
  output logic             pix_ready,
  output mnt_pkg::result_t result,
  output logic             result_valid,
  input  logic             result_ready
);
  import mnt_pkg::*;

  logic     wr_en;
  pixel_t   wr_pix;
  coord_x_t fetch_x;
  coord_y_t fetch_y;
  logic     fetch_center;
  nbr_t     nbr;
  logic     center_bit;
  delta_t   move_dx;
  delta_t   move_dy;
  dir_t     next_from;
  dir_t     from;
  logic     has_move;

  contour_controller #(
    .WIDTH  (WIDTH),
    .HEIGHT (HEIGHT)
  ) u_contour_controller (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .pix          (pix),
    .pix_valid    (pix_valid),
    .pix_ready    (pix_ready),
    .wr_en        (wr_en),
    .wr_pix       (wr_pix),
    .fetch_x      (fetch_x),
    .fetch_y      (fetch_y),
    .fetch_center (fetch_center),
    .center_bit   (center_bit),
    .move_dx      (move_dx),
    .move_dy      (move_dy),
    .next_from    (next_from),
    .has_move     (has_move),
    .from         (from),
    .result       (result),
    .result_valid (result_valid),
    .result_ready (result_ready)
  );

  // frame store with one cycle from address to neighbors
  neighbor_window #(
    .WIDTH  (WIDTH),
    .HEIGHT (HEIGHT)
  ) u_neighbor_window (
    .clk_in       (clk_in),
    .wr_en        (wr_en),
    .wr_pix       (wr_pix),
    .fetch_x      (fetch_x),
    .fetch_y      (fetch_y),
    .fetch_center (fetch_center),
    .nbr          (nbr),
    .center_bit   (center_bit)
  );

  moore_step u_moore_step (
    .from      (from),
    .nbr       (nbr),
    .move_dx   (move_dx),
    .move_dy   (move_dy),
    .next_from (next_from),
    .has_move  (has_move)
  );

endmodule

//--- testbench/result_checker.sv
`timescale 1ns/1ps

module result_checker #(
  parameter int ROWS = 1
) (
  input  logic             clk_in,
  input  logic             rst_in,
  input  logic             pix_ready,
  input  mnt_pkg::result_t result,
  input  logic             result_valid,
  input  logic             result_ready,
  input  mnt_pkg::result_t exp_table [ROWS],
  output int               results_seen,
  output int               check_count,
  output int               error_count
);
  import mnt_pkg::*;

  result_t held;     // value seen while the sink stalled
  logic    holding;
  logic    rst_q;

  task automatic check_field(input string name, input int got, input int want);
    check_count++;
    if (got != want) begin
      error_count++;
      $display("error at %0d ns: %s got %0d expected %0d", $time, name, got, want);
    end
  endtask

  task automatic compare_result(input result_t got);
    result_t want;
    string   tag;
    if (results_seen >= ROWS) begin
      error_count++;
      $display("a result arrived after the last frame had been reported");
      return;
    end
    want = exp_table[results_seen];
    tag  = $sformatf("frame %0d result", results_seen);
    check_field({tag, ".found"}, int'(got.found), int'(want.found));
    check_field({tag, ".start_x"}, int'(got.start_x), int'(want.start_x));
    check_field({tag, ".start_y"}, int'(got.start_y), int'(want.start_y));
    check_field({tag, ".perimeter"}, int'(got.perimeter), int'(want.perimeter));
  endtask

  always @(posedge clk_in) begin
    if (rst_q) begin
      check_count++;
      if (pix_ready !== 1'b0) begin
        error_count++;
        $display("error at %0d ns: pix_ready got %b expected 0", $time, pix_ready);
      end
      if (result_valid !== 1'b0) begin
        error_count++;
        $display("error at %0d ns: result_valid got %b expected 0", $time, result_valid);
      end
      if (result !== '0) begin
        error_count++;
        $display("error at %0d ns: result got %h expected 0", $time, result);
      end
    end
    rst_q <= rst_in;
    if (rst_in) begin
      holding <= 1'b0;
    end else if (result_valid) begin
      check_count++;
      if (pix_ready) begin  // next frame must be held back
        error_count++;
        $display("error at %0d ns: pix_ready got 1 expected 0", $time);
      end
      if (holding && result !== held) begin
        error_count++;
        $display("error at %0d ns: result got %h expected %h", $time, result, held);
      end
      if (result_ready) begin
        compare_result(result);
        results_seen <= results_seen + 1;
        holding      <= 1'b0;
      end else begin
        holding <= 1'b1;
        held    <= result;
      end
    end else if (holding) begin
      error_count++;
      $display("result_valid dropped before the sink took the result");
      holding <= 1'b0;
    end
  end

endmodule

//--- testbench/tb_contour_tracer.sv
`timescale 1ns/1ps

module tb_contour_tracer;
  import mnt_pkg::*;

  localparam int WIDTH      = 16;
  localparam int HEIGHT     = 12;
  localparam int CLK_PERIOD = 40;
  localparam int NUM_ROWS   = 12;
  localparam int RAND_LEN   = 64;
  localparam int SEED       = 32'h7b1ff1d1;
  localparam longint TIMEOUT_NS = longint'(NUM_ROWS) * 6 * WIDTH * HEIGHT * CLK_PERIOD;

  localparam int SHAPE_EMPTY = 0;
  localparam int SHAPE_RECT  = 1;  // one rectangle, dots and lines included
  localparam int SHAPE_TWO   = 2;

  typedef struct packed {
    int      kind;
    int      ax0;
    int      ay0;
    int      ax1;
    int      ay1;
    int      bx0;
    int      by0;
    int      bx1;
    int      by1;
    int      hold;  // extra cycles with result_ready low
    result_t want;
  } row_t;

  logic    clk_in;
  logic    rst_in;
  pixel_t  pix;
  logic    pix_valid;
  logic    pix_ready;
  result_t result;
  logic    result_valid;
  logic    result_ready;
  logic    hold_ready;

  row_t    shape_rows [NUM_ROWS];
  result_t exp_table [NUM_ROWS];
  int      gap_len [RAND_LEN];
  logic    ready_pat [RAND_LEN];
  int      results_seen;
  int      check_count;
  int      error_count;

  contour_tracer_top #(
    .WIDTH  (WIDTH),
    .HEIGHT (HEIGHT)
  ) u_contour_tracer_top (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .pix          (pix),
    .pix_valid    (pix_valid),
    .pix_ready    (pix_ready),
    .result       (result),
    .result_valid (result_valid),
    .result_ready (result_ready)
  );

  result_checker #(
    .ROWS (NUM_ROWS)
  ) u_result_checker (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .pix_ready    (pix_ready),
    .result       (result),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .exp_table    (exp_table),
    .results_seen (results_seen),
    .check_count  (check_count),
    .error_count  (error_count)
  );

  function automatic int rect_perimeter(input int w, input int h);
    if (w == 1 && h == 1) begin
      return 1;
    end
    if (h == 1) begin
      return 2 * w - 2;  // out along the line and back
    end
    return 2 * w + 2 * h - 4;
  endfunction

  function automatic result_t rect_result(input int x0, input int y0, input int x1, input int y1);
    result_t res;
    res.found     = 1'b1;
    res.start_x   = coord_x_t'(x0);
    res.start_y   = coord_y_t'(y0);
    res.perimeter = perim_t'(rect_perimeter(x1 - x0 + 1, y1 - y0 + 1));
    return res;
  endfunction

  function automatic row_t make_row(input int kind, input int ax0, input int ay0,
                                    input int ax1, input int ay1, input int bx0,
                                    input int by0, input int bx1, input int by1,
                                    input int hold);
    row_t r;
    logic a_first;
    r.kind = kind;
    r.ax0  = ax0;
    r.ay0  = ay0;
    r.ax1  = ax1;
    r.ay1  = ay1;
    r.bx0  = bx0;
    r.by0  = by0;
    r.bx1  = bx1;
    r.by1  = by1;
    r.hold = hold;
    r.want = '0;
    // raster order decides which top-left corner is found first
    a_first = kind == SHAPE_RECT || ay0 < by0 || (ay0 == by0 && ax0 < bx0);
    if (kind != SHAPE_EMPTY) begin
      r.want = a_first ? rect_result(ax0, ay0, ax1, ay1) : rect_result(bx0, by0, bx1, by1);
    end
    return r;
  endfunction

  function automatic logic pixel_set(input row_t r, input int x, input int y);
    logic in_a;
    logic in_b;
    in_a = x >= r.ax0 && x <= r.ax1 && y >= r.ay0 && y <= r.ay1;
    in_b = x >= r.bx0 && x <= r.bx1 && y >= r.by0 && y <= r.by1;
    case (r.kind)
      SHAPE_RECT: return in_a;
      SHAPE_TWO:  return in_a | in_b;
      default:    return 1'b0;
    endcase
  endfunction

  task automatic build_table();
    shape_rows[0]  = make_row(SHAPE_EMPTY, 0, 0, 0, 0, 0, 0, 0, 0, 0);
    shape_rows[1]  = make_row(SHAPE_RECT, 7, 5, 7, 5, 0, 0, 0, 0, 0);      // single dot
    shape_rows[2]  = make_row(SHAPE_RECT, 15, 11, 15, 11, 0, 0, 0, 0, 0);  // last pixel
    shape_rows[3]  = make_row(SHAPE_RECT, 3, 2, 6, 5, 0, 0, 0, 0, 0);
    shape_rows[4]  = make_row(SHAPE_RECT, 0, 0, 4, 2, 0, 0, 0, 0, 0);      // top-left edges
    shape_rows[5]  = make_row(SHAPE_RECT, 11, 7, 15, 11, 0, 0, 0, 0, 0);   // bottom-right edges
    shape_rows[6]  = make_row(SHAPE_RECT, 2, 9, 9, 9, 0, 0, 0, 0, 0);      // horizontal line
    shape_rows[7]  = make_row(SHAPE_RECT, 13, 0, 15, 0, 0, 0, 0, 0, 0);
    shape_rows[8]  = make_row(SHAPE_TWO, 9, 1, 12, 3, 2, 6, 5, 9, 20);
    shape_rows[9]  = make_row(SHAPE_TWO, 6, 3, 9, 4, 1, 3, 3, 8, 0);
    shape_rows[10] = make_row(SHAPE_RECT, 0, 0, 15, 11, 0, 0, 0, 0, 30);   // whole frame
    shape_rows[11] = make_row(SHAPE_RECT, 5, 4, 6, 5, 0, 0, 0, 0, 0);
    for (int i = 0; i < NUM_ROWS; i++) begin
      exp_table[i] = shape_rows[i].want;
    end
  endtask

  task automatic fill_random();
    for (int i = 0; i < RAND_LEN; i++) begin
      gap_len[i]   = ($urandom % 4 == 0) ? 1 + int'($urandom % 2) : 0;
      ready_pat[i] = ($urandom % 3) != 0;
    end
  endtask

  // called just after a rising edge, returns on the edge of the transfer
  task automatic send_pixel(input pixel_t p, input int gap);
    if (gap > 0) begin
      pix_valid <= 1'b0;
      repeat (gap) @(posedge clk_in);
    end
    pix       <= p;
    pix_valid <= 1'b1;
    @(posedge clk_in);
    while (!pix_ready) begin
      @(posedge clk_in);
    end
  endtask

  task automatic send_frame(input int r);
    pixel_t p;
    int     n;
    n = 0;
    for (int y = 0; y < HEIGHT; y++) begin
      for (int x = 0; x < WIDTH; x++) begin
        p.x      = coord_x_t'(x);
        p.y      = coord_y_t'(y);
        p.masked = pixel_set(shape_rows[r], x, y);
        p.sof    = x == 0 && y == 0;
        send_pixel(p, gap_len[(n + 7 * r) % RAND_LEN]);
        n++;
      end
    end
    pix_valid <= 1'b0;
    if (shape_rows[r].hold > 0) begin
      hold_ready <= 1'b1;  // stall the sink once the result shows up
      while (!result_valid) begin
        @(posedge clk_in);
      end
      repeat (shape_rows[r].hold) @(posedge clk_in);
      hold_ready <= 1'b0;
    end
  endtask

  initial begin
    clk_in = 1'b0;
    forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
  end

  initial begin : ready_driver
    int cyc;
    result_ready = 1'b0;
    cyc = 0;
    forever begin
      @(posedge clk_in);
      result_ready <= !hold_ready && ready_pat[cyc % RAND_LEN];
      cyc++;
    end
  end

  initial begin
    void'($urandom(SEED));
    rst_in     = 1'b1;
    pix        = '0;
    pix_valid  = 1'b0;
    hold_ready = 1'b0;
    fill_random();
    build_table();
    repeat (5) @(posedge clk_in);
    rst_in <= 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      send_frame(r);
    end
    while (results_seen < NUM_ROWS) begin
      @(posedge clk_in);
    end
    repeat (2) @(posedge clk_in);
    $display("frames %0d, checks %0d, errors %0d", results_seen, check_count, error_count);
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("timeout: frame %0d did not finish within %0d ns", results_seen, TIMEOUT_NS);
    $display("frames %0d, checks %0d, errors %0d", results_seen, check_count, error_count);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- contour_tracer_top.f
rtl/mnt_pkg.sv
rtl/mask_bram.sv
rtl/neighbor_window.sv
rtl/moore_step.sv
rtl/contour_controller.sv
rtl/contour_tracer_top.sv
testbench/result_checker.sv
testbench/tb_contour_tracer.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal --top-module tb_contour_tracer \
    -f contour_tracer_top.f -o sim_tb; then
  echo "verilator build failed"
  exit 1
fi

if ! output=$(./obj_dir/sim_tb 2>&1); then
  echo "$output"
  echo "simulation exited with an error status"
  exit 1
fi
echo "$output"

if grep -qx "ALL CHECKS PASSED" <<< "$output"; then
  exit 0
fi
echo "simulation did not report a pass"
exit 1
